/* Makefile */
VERILATOR := verilator
FLAGS     := --timing --assert --timescale 1ns/1ps
TOP       := tb_rv_core
FILELIST  := filelist.f
BUILD     := obj_dir
LOG       := sim.log

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

sim: build
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q '>>> PASS' $(LOG); then echo "simulation ended early"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD) $(LOG)

/* decode_stage.sv */
`include "rv_cfg.svh"

module decode_stage (
    input  logic             clock,
    input  logic             reset,
    input  logic             instr_valid,
    output logic             instr_ready,
    input  logic [`XLEN-1:0] instr_pc,
    input  logic [31:0]      instr_data,
    input  logic             redirect,
    input  logic [`XLEN-1:0] redirect_target,
    input  logic             exe_ready,
    output logic             dec_valid,
    output logic [`XLEN-1:0] dec_pc,
    output logic [`XLEN-1:0] dec_imm,
    output logic [4:0]       dec_waddr,
    output logic [4:0]       dec_raddr1,
    output logic [4:0]       dec_raddr2,
    output logic             dec_wren,
    output logic             dec_rden1,
    output logic             dec_rden2,
    output logic             dec_auipc,
    output logic             dec_lui,
    output logic             dec_jal,
    output logic             dec_jalr,
    output logic             dec_branch,
    output logic             dec_ecall,
    output logic             dec_ebreak,
    output logic             dec_legal,
    output rv_pkg::alu_op_t  dec_alu_op,
    output rv_pkg::bcu_op_t  dec_bcu_op,
    output logic [31:0]      dec_instr
);
    import rv_pkg::*;

    logic             active;
    logic             hold;
    logic             keep;
    logic [`XLEN-1:0] expect_pc;
    logic [`XLEN-1:0] match_pc;
    logic [31:0]      next_instr;
    logic [`XLEN-1:0] d_imm;
    logic [4:0]       d_waddr;
    logic [4:0]       d_raddr1;
    logic [4:0]       d_raddr2;
    logic             d_wren;
    logic             d_rden1;
    logic             d_rden2;
    logic             d_auipc;
    logic             d_lui;
    logic             d_jal;
    logic             d_jalr;
    logic             d_branch;
    logic             d_ecall;
    logic             d_ebreak;
    logic             d_legal;
    alu_op_t          d_alu_op;
    bcu_op_t          d_bcu_op;

    assign hold = dec_valid && !exe_ready;
    assign instr_ready = active && !hold;
    assign match_pc = redirect ? redirect_target : expect_pc;  // a jump target wins at once.
    assign keep = instr_valid && instr_ready && (instr_pc == match_pc);
    assign next_instr = keep ? instr_data : `NOP_INSTR;

    instr_decoder instr_decoder_inst (
        .instr  (next_instr),
        .imm    (d_imm),
        .waddr  (d_waddr),
        .raddr1 (d_raddr1),
        .raddr2 (d_raddr2),
        .wren   (d_wren),
        .rden1  (d_rden1),
        .rden2  (d_rden2),
        .auipc  (d_auipc),
        .lui    (d_lui),
        .jal    (d_jal),
        .jalr   (d_jalr),
        .branch (d_branch),
        .ecall  (d_ecall),
        .ebreak (d_ebreak),
        .legal  (d_legal),
        .alu_op (d_alu_op),
        .bcu_op (d_bcu_op)
    );

    always_ff @(posedge clock) begin
        if (!reset) begin
            active <= 1'b0;
            dec_valid <= 1'b0;
            expect_pc <= `RESET_PC;
        end else begin
            active <= 1'b1;
            dec_valid <= keep || hold;  // an entry leaving to execute empties the register.
            expect_pc <= keep ? match_pc + 4 : match_pc;
        end
    end

    always_ff @(posedge clock) begin
        if (!hold) begin
            dec_pc <= instr_pc;
            dec_instr <= next_instr;
            dec_imm <= d_imm;
            dec_waddr <= d_waddr;
            dec_raddr1 <= d_raddr1;
            dec_raddr2 <= d_raddr2;
            dec_wren <= d_wren;
            dec_rden1 <= d_rden1;
            dec_rden2 <= d_rden2;
            dec_auipc <= d_auipc;
            dec_lui <= d_lui;
            dec_jal <= d_jal;
            dec_jalr <= d_jalr;
            dec_branch <= d_branch;
            dec_ecall <= d_ecall;
            dec_ebreak <= d_ebreak;
            dec_legal <= d_legal;
            dec_alu_op <= d_alu_op;
            dec_bcu_op <= d_bcu_op;
        end
    end

    assert property (@(posedge clock) disable iff (!reset)
        redirect |=> !dec_valid || $past(instr_pc) == $past(redirect_target));

endmodule

/* execute_stage.sv */
`include "rv_cfg.svh"

module execute_stage (
    input  logic              clock,
    input  logic              reset,
    input  logic              dec_valid,
    input  logic [`XLEN-1:0]  dec_pc,
    input  logic [`XLEN-1:0]  dec_imm,
    input  logic [4:0]        dec_waddr,
    input  logic [4:0]        dec_raddr1,
    input  logic [4:0]        dec_raddr2,
    input  logic              dec_wren,
    input  logic              dec_rden1,
    input  logic              dec_rden2,
    input  logic              dec_auipc,
    input  logic              dec_lui,
    input  logic              dec_jal,
    input  logic              dec_jalr,
    input  logic              dec_branch,
    input  logic              dec_ecall,
    input  logic              dec_ebreak,
    input  logic              dec_legal,
    input  rv_pkg::alu_op_t   dec_alu_op,
    input  rv_pkg::bcu_op_t   dec_bcu_op,
    input  logic [31:0]       dec_instr,
    output logic              exe_ready,
    input  logic [`XLEN-1:0]  rdata1,
    input  logic [`XLEN-1:0]  rdata2,
    input  logic              res_fwd_valid,
    input  logic [4:0]        res_fwd_waddr,
    input  logic [`XLEN-1:0]  res_fwd_wdata,
    input  logic              res_ready,
    output logic              exe_valid,
    output logic [`XLEN-1:0]  exe_pc,
    output logic              exe_wren,
    output logic [4:0]        exe_waddr,
    output logic [`XLEN-1:0]  exe_wdata,
    output logic              exe_jump,
    output logic [`XLEN-1:0]  exe_target,
    output logic              exe_exception,
    output rv_pkg::ecause_t   exe_ecause,
    output logic              redirect,
    output logic [`XLEN-1:0]  redirect_target
);
    import rv_pkg::*;

    logic             transfer;
    logic [`XLEN-1:0] op1;
    logic [`XLEN-1:0] op2;
    logic [`XLEN-1:0] alu_a;
    logic [`XLEN-1:0] alu_b;
    logic [`XLEN-1:0] alu_res;
    logic [`XLEN-1:0] target;
    logic             taken;
    logic             jump;
    logic             wren;
    logic [`XLEN-1:0] wdata;
    logic             exception;
    ecause_t          ecause;

    // the younger write in the execute register beats the one waiting to retire.
    function automatic logic [`XLEN-1:0] bypass(input logic [4:0] addr,
                                                input logic [`XLEN-1:0] file_data);
        if (exe_valid && exe_wren && exe_waddr == addr) begin
            return exe_wdata;
        end else if (res_fwd_valid && res_fwd_waddr == addr) begin
            return res_fwd_wdata;
        end
        return file_data;
    endfunction

    assign exe_ready = !exe_valid || res_ready;
    assign transfer = dec_valid && exe_ready;
    assign op1 = dec_rden1 ? bypass(dec_raddr1, rdata1) : '0;
    assign op2 = dec_rden2 ? bypass(dec_raddr2, rdata2) : '0;
    assign alu_a = dec_auipc ? dec_pc : (dec_lui ? '0 : op1);
    assign alu_b = dec_rden2 ? op2 : dec_imm;

    always_comb begin
        case (dec_alu_op)
            alu_add: alu_res = alu_a + alu_b;
            alu_sub: alu_res = alu_a - alu_b;
            alu_sll: alu_res = alu_a << alu_b[4:0];
            alu_slt: alu_res = `XLEN'($signed(alu_a) < $signed(alu_b));
            alu_sltu: alu_res = `XLEN'(alu_a < alu_b);
            alu_xor: alu_res = alu_a ^ alu_b;
            alu_srl: alu_res = alu_a >> alu_b[4:0];
            alu_sra: alu_res = $signed(alu_a) >>> alu_b[4:0];
            alu_or: alu_res = alu_a | alu_b;
            alu_and: alu_res = alu_a & alu_b;
            default: alu_res = alu_b;
        endcase
    end

    always_comb begin
        case (dec_bcu_op)
            bcu_beq: taken = (op1 == op2);
            bcu_bne: taken = (op1 != op2);
            bcu_blt: taken = ($signed(op1) < $signed(op2));
            bcu_bge: taken = ($signed(op1) >= $signed(op2));
            bcu_bltu: taken = (op1 < op2);
            bcu_bgeu: taken = (op1 >= op2);
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        target = dec_jalr ? ((op1 + dec_imm) & ~`XLEN'd1) : dec_pc + dec_imm;
        jump = dec_jal || dec_jalr || (dec_branch && taken);
        wren = dec_wren;
        wdata = (dec_jal || dec_jalr) ? dec_pc + 4 : alu_res;
        exception = 1'b1;
        ecause = except_misaligned_fetch;
        if (!dec_legal) begin
            ecause = except_illegal_instruction;
        end else if (dec_ebreak) begin
            ecause = except_breakpoint;
        end else if (dec_ecall) begin
            ecause = except_env_call_mach;
        end else if (!(jump && target[1])) begin
            exception = 1'b0;
        end
        if (exception) begin
            wren = 1'b0;
            jump = 1'b0;
        end
    end

    assign redirect = transfer && jump;
    assign redirect_target = target;

    always_ff @(posedge clock) begin
        if (!reset) begin
            exe_valid <= 1'b0;
        end else if (exe_ready) begin
            exe_valid <= dec_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (transfer) begin
            exe_pc <= dec_pc;
            exe_wren <= wren;
            exe_waddr <= dec_waddr;
            exe_wdata <= wdata;
            exe_jump <= jump;
            exe_target <= target;
            exe_exception <= exception;
            exe_ecause <= ecause;
        end
    end

    // decode refills itself with the nop whenever it has nothing to offer.
    assert property (@(posedge clock) disable iff (!reset)
        !dec_valid |-> dec_instr == `NOP_INSTR);

endmodule

/* filelist.f */
+incdir+.
rv_pkg.sv
instr_decoder.sv
register_file.sv
decode_stage.sv
execute_stage.sv
result_stage.sv
rv_core.sv
tb_rv_core.sv

/* instr_decoder.sv */
`include "rv_cfg.svh"

module instr_decoder (
    input  logic [31:0]      instr,
    output logic [`XLEN-1:0] imm,
    output logic [4:0]       waddr,
    output logic [4:0]       raddr1,
    output logic [4:0]       raddr2,
    output logic             wren,
    output logic             rden1,
    output logic             rden2,
    output logic             auipc,
    output logic             lui,
    output logic             jal,
    output logic             jalr,
    output logic             branch,
    output logic             ecall,
    output logic             ebreak,
    output logic             legal,
    output rv_pkg::alu_op_t  alu_op,
    output rv_pkg::bcu_op_t  bcu_op
);
    import rv_pkg::*;

    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic             writes;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_j;

    function automatic alu_op_t alu_sel(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000: return alt ? alu_sub : alu_add;
            3'b001: return alu_sll;
            3'b010: return alu_slt;
            3'b011: return alu_sltu;
            3'b100: return alu_xor;
            3'b101: return alt ? alu_sra : alu_srl;
            3'b110: return alu_or;
            default: return alu_and;
        endcase
    endfunction

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign waddr = instr[11:7];
    assign raddr1 = instr[19:15];
    assign raddr2 = instr[24:20];
    assign imm_i = {{(`XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_b = {{(`XLEN-12){instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{(`XLEN-20){instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    assign wren = writes && (waddr != 5'd0);  // x0 is never written.

    always_comb begin
        imm = '0;
        writes = 1'b0;
        rden1 = 1'b0;
        rden2 = 1'b0;
        auipc = 1'b0;
        lui = 1'b0;
        jal = 1'b0;
        jalr = 1'b0;
        branch = 1'b0;
        ecall = 1'b0;
        ebreak = 1'b0;
        legal = 1'b0;
        alu_op = alu_add;
        bcu_op = bcu_none;
        case (opcode)
            7'b0110111: begin
                lui = 1'b1;
                writes = 1'b1;
                imm = imm_u;
                alu_op = alu_pass_b;
                legal = 1'b1;
            end
            7'b0010111: begin
                auipc = 1'b1;
                writes = 1'b1;
                imm = imm_u;
                legal = 1'b1;
            end
            7'b1101111: begin
                jal = 1'b1;
                writes = 1'b1;
                imm = imm_j;
                legal = 1'b1;
            end
            7'b1100111: begin
                jalr = 1'b1;
                writes = 1'b1;
                rden1 = 1'b1;
                imm = imm_i;
                legal = (funct3 == 3'b000);
            end
            7'b1100011: begin
                branch = 1'b1;
                rden1 = 1'b1;
                rden2 = 1'b1;
                imm = imm_b;
                legal = (funct3[2:1] != 2'b01);  // funct3 010 and 011 are reserved.
                case (funct3)
                    3'b000: bcu_op = bcu_beq;
                    3'b001: bcu_op = bcu_bne;
                    3'b100: bcu_op = bcu_blt;
                    3'b101: bcu_op = bcu_bge;
                    3'b110: bcu_op = bcu_bltu;
                    3'b111: bcu_op = bcu_bgeu;
                    default: bcu_op = bcu_none;
                endcase
            end
            7'b0010011: begin
                writes = 1'b1;
                rden1 = 1'b1;
                imm = imm_i;
                alu_op = alu_sel(funct3, (funct3 == 3'b101) && instr[30]);
                if (funct3 == 3'b001) begin
                    legal = (funct7 == 7'b0000000);
                end else if (funct3 == 3'b101) begin
                    legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                end else begin
                    legal = 1'b1;
                end
            end
            7'b0110011: begin
                writes = 1'b1;
                rden1 = 1'b1;
                rden2 = 1'b1;
                alu_op = alu_sel(funct3, instr[30]);
                legal = (funct7 == 7'b0000000) ||
                        ((funct7 == 7'b0100000) && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            7'b1110011: begin
                ecall = (instr == 32'h0000_0073);
                ebreak = (instr == 32'h0010_0073);
                legal = ecall || ebreak;
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

endmodule

/* register_file.sv */
`include "rv_cfg.svh"

module register_file (
    input  logic             clock,
    input  logic [4:0]       raddr1,
    input  logic [4:0]       raddr2,
    output logic [`XLEN-1:0] rdata1,
    output logic [`XLEN-1:0] rdata2,
    input  logic             wren,
    input  logic [4:0]       waddr,
    input  logic [`XLEN-1:0] wdata
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge clock) begin
        if (wren && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

    // the decoder drops wren for rd x0, so a retiring write never aims at it.
    assert property (@(posedge clock) wren |-> waddr != 5'd0);

endmodule

/* result_stage.sv */
`include "rv_cfg.svh"

module result_stage (
    input  logic             clock,
    input  logic             reset,
    input  logic             exe_valid,
    input  logic [`XLEN-1:0] exe_pc,
    input  logic             exe_wren,
    input  logic [4:0]       exe_waddr,
    input  logic [`XLEN-1:0] exe_wdata,
    input  logic             exe_jump,
    input  logic [`XLEN-1:0] exe_target,
    input  logic             exe_exception,
    input  rv_pkg::ecause_t  exe_ecause,
    output logic             res_ready,
    output logic             retire_valid,
    output logic [`XLEN-1:0] retire_pc,
    output logic             retire_wren,
    output logic [4:0]       retire_waddr,
    output logic [`XLEN-1:0] retire_wdata,
    output logic             retire_jump,
    output logic [`XLEN-1:0] retire_target,
    output logic             retire_exception,
    output rv_pkg::ecause_t  retire_ecause,
    input  logic             retire_ready,
    output logic             rf_wren,
    output logic [4:0]       rf_waddr,
    output logic [`XLEN-1:0] rf_wdata,
    output logic             res_fwd_valid,
    output logic [4:0]       res_fwd_waddr,
    output logic [`XLEN-1:0] res_fwd_wdata
);

    assign res_ready = !retire_valid || retire_ready;
    assign rf_wren = retire_valid && retire_ready && retire_wren;  // commit on the handshake.
    assign rf_waddr = retire_waddr;
    assign rf_wdata = retire_wdata;
    assign res_fwd_valid = retire_valid && retire_wren;
    assign res_fwd_waddr = retire_waddr;
    assign res_fwd_wdata = retire_wdata;

    always_ff @(posedge clock) begin
        if (!reset) begin
            retire_valid <= 1'b0;
        end else if (res_ready) begin
            retire_valid <= exe_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (res_ready && exe_valid) begin
            retire_pc <= exe_pc;
            retire_wren <= exe_wren;
            retire_waddr <= exe_waddr;
            retire_wdata <= exe_wdata;
            retire_jump <= exe_jump;
            retire_target <= exe_target;
            retire_exception <= exe_exception;
            retire_ecause <= exe_ecause;
        end
    end

    assert property (@(posedge clock) disable iff (!reset)
        retire_valid && !retire_ready |=> retire_valid &&
        $stable({retire_pc, retire_wren, retire_waddr, retire_wdata, retire_jump,
                 retire_target, retire_exception, retire_ecause}));

endmodule

/* rv_cfg.svh */
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

`define XLEN 32
`define REG_COUNT 32
`define RESET_PC 32'h0000_0000

// addi x0,x0,0 fills the decode register while it is empty.
`define NOP_INSTR 32'h0000_0013

`endif

/* rv_core.sv */
`include "rv_cfg.svh"

module rv_core (
    input  logic             clock,
    input  logic             reset,
    input  logic             instr_valid,
    output logic             instr_ready,
    input  logic [`XLEN-1:0] instr_pc,
    input  logic [31:0]      instr_data,
    output logic             retire_valid,
    input  logic             retire_ready,
    output logic [`XLEN-1:0] retire_pc,
    output logic             retire_wren,
    output logic [4:0]       retire_waddr,
    output logic [`XLEN-1:0] retire_wdata,
    output logic             retire_jump,
    output logic [`XLEN-1:0] retire_target,
    output logic             retire_exception,
    output rv_pkg::ecause_t  retire_ecause
);
    import rv_pkg::*;

    logic             redirect;
    logic [`XLEN-1:0] redirect_target;
    logic             exe_ready;
    logic             dec_valid;
    logic [`XLEN-1:0] dec_pc;
    logic [`XLEN-1:0] dec_imm;
    logic [4:0]       dec_waddr;
    logic [4:0]       dec_raddr1;
    logic [4:0]       dec_raddr2;
    logic             dec_wren;
    logic             dec_rden1;
    logic             dec_rden2;
    logic             dec_auipc;
    logic             dec_lui;
    logic             dec_jal;
    logic             dec_jalr;
    logic             dec_branch;
    logic             dec_ecall;
    logic             dec_ebreak;
    logic             dec_legal;
    alu_op_t          dec_alu_op;
    bcu_op_t          dec_bcu_op;
    logic [31:0]      dec_instr;
    logic [`XLEN-1:0] rdata1;
    logic [`XLEN-1:0] rdata2;
    logic             res_ready;
    logic             exe_valid;
    logic [`XLEN-1:0] exe_pc;
    logic             exe_wren;
    logic [4:0]       exe_waddr;
    logic [`XLEN-1:0] exe_wdata;
    logic             exe_jump;
    logic [`XLEN-1:0] exe_target;
    logic             exe_exception;
    ecause_t          exe_ecause;
    logic             rf_wren;
    logic [4:0]       rf_waddr;
    logic [`XLEN-1:0] rf_wdata;
    logic             res_fwd_valid;
    logic [4:0]       res_fwd_waddr;
    logic [`XLEN-1:0] res_fwd_wdata;

    decode_stage decode_stage_inst (.*);

    register_file register_file_inst (
        .clock  (clock),
        .raddr1 (dec_raddr1),
        .raddr2 (dec_raddr2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .wren   (rf_wren),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    execute_stage execute_stage_inst (.*);

    result_stage result_stage_inst (.*);

endmodule

/* rv_golden.hex */
// pc instr retires wren waddr wdata jump target exception ecause
// fields that a line does not use hold zero; lines with retires 0 are wrong-path.
00000000 00500093 1 1 01 00000005 0 00000000 0 0
00000004 ffd08113 1 1 02 00000002 0 00000000 0 0
00000008 002081b3 1 1 03 00000007 0 00000000 0 0
0000000c 40118233 1 1 04 00000002 0 00000000 0 0
00000010 123452b7 1 1 05 12345000 0 00000000 0 0
00000014 00001317 1 1 06 00001014 0 00000000 0 0
00000018 fff2c393 1 1 07 edcbafff 0 00000000 0 0
0000001c 4043d413 1 1 08 fedcbaff 0 00000000 0 0
00000020 001424b3 1 1 09 00000001 0 00000000 0 0
00000024 00143533 1 1 0a 00000000 0 00000000 0 0
00000028 00908013 1 0 00 00000000 0 00000000 0 0
0000002c 000005b3 1 1 0b 00000000 0 00000000 0 0
00000030 0100066f 1 1 0c 00000034 1 00000040 0 0
00000034 06300093 0 0 00 00000000 0 00000000 0 0
00000038 04d00113 0 0 00 00000000 0 00000000 0 0
00000040 02460693 1 1 0d 00000058 0 00000000 0 0
00000044 00868767 1 1 0e 00000048 1 00000060 0 0
00000048 00100093 0 0 00 00000000 0 00000000 0 0
00000060 00108863 1 0 00 00000000 1 00000070 0 0
00000064 00200093 0 0 00 00000000 0 00000000 0 0
00000070 00109463 1 0 00 00000000 0 00000000 0 0
00000074 00144663 1 0 00 00000000 1 00000080 0 0
00000078 00300093 0 0 00 00000000 0 00000000 0 0
00000080 00146463 1 0 00 00000000 0 00000000 0 0
00000084 0020d663 1 0 00 00000000 1 00000090 0 0
00000088 00400093 0 0 00 00000000 0 00000000 0 0
00000090 0080f463 1 0 00 00000000 0 00000000 0 0
00000094 021080b3 1 0 00 00000000 0 00000000 1 2
00000098 ffffffff 1 0 00 00000000 0 00000000 1 2
0000009c 00000073 1 0 00 00000000 0 00000000 1 b
000000a0 00100073 1 0 00 00000000 0 00000000 1 3
000000a4 00208167 1 0 00 00000000 0 00000006 1 0
000000a8 002087b3 1 1 0f 00000007 0 00000000 0 0
000000ac 00209833 1 1 10 00000014 0 00000000 0 0
000000b0 00d878b3 1 1 11 00000010 0 00000000 0 0
000000b4 00245933 1 1 12 3fb72ebf 0 00000000 0 0
000000b8 00d969b3 1 1 13 3fb72eff 0 00000000 0 0
000000bc 0060bb13 1 1 16 00000001 0 00000000 0 0

/* rv_pkg.sv */
package rv_pkg;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b  // operand b straight through, used by lui.
    } alu_op_t;

    typedef enum logic [2:0] {
        bcu_none,
        bcu_beq,
        bcu_bne,
        bcu_blt,
        bcu_bge,
        bcu_bltu,
        bcu_bgeu
    } bcu_op_t;

    typedef enum logic [3:0] {
        except_misaligned_fetch    = 4'd0,
        except_illegal_instruction = 4'd2,
        except_breakpoint          = 4'd3,
        except_env_call_mach       = 4'd11
    } ecause_t;

endpackage

/* tb_rv_core.sv */
`include "rv_cfg.svh"

module tb_rv_core;
    timeunit 1ns;
    timeprecision 100ps;
    import rv_pkg::*;

    localparam int MAX_LINES = 64;
    localparam int FIELDS = 10;  // pc, instr, retires, wren, waddr, wdata, jump, target, exc, cause.

    logic             clock;
    logic             reset;
    logic             instr_valid;
    logic             instr_ready;
    logic [`XLEN-1:0] instr_pc;
    logic [31:0]      instr_data;
    logic             retire_valid;
    logic             retire_ready;
    logic [`XLEN-1:0] retire_pc;
    logic             retire_wren;
    logic [4:0]       retire_waddr;
    logic [`XLEN-1:0] retire_wdata;
    logic             retire_jump;
    logic [`XLEN-1:0] retire_target;
    logic             retire_exception;
    ecause_t          retire_ecause;

    logic [31:0] golden [MAX_LINES*FIELDS];
    int          expect_q [$];
    int          line_count;
    int          next_line;
    int          cycle_count;
    int          timeout_limit;
    logic [31:0] lfsr_state;

    rv_core rv_core_inst (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    function automatic logic [31:0] fill_word(input int index);
        return ~32'(index);  // no aligned pc looks like this.
    endfunction

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic take_bit(output logic bit_out);
        lfsr_state = lfsr_step(lfsr_state);
        bit_out = lfsr_state[0];
    endtask

    // true about one time in four.
    task automatic roll_quarter(output logic hit);
        logic first;
        logic second;
        take_bit(first);
        take_bit(second);
        hit = first & second;
    endtask

    task automatic abort_run(input string reason);
        $display("run stopped: %s", reason);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %0d ns: %s expected %h, got %h", $time, name, expected, actual);
            abort_run("a retired value differs from the golden trace");
        end
    endtask

    task automatic offer_line(input int line);
        instr_valid = 1'b1;
        instr_pc = golden[line*FIELDS];
        instr_data = golden[line*FIELDS+1];
    endtask

    task automatic check_retire();
        int base;
        if (expect_q.size() == 0) begin
            abort_run($sformatf("pc %h retired although nothing was left to retire",
                                retire_pc));
        end else begin
            base = expect_q.pop_front() * FIELDS;
            check_value("retire_pc", golden[base], retire_pc);
            check_value("retire_wren", golden[base+3], 32'(retire_wren));
            check_value("retire_jump", golden[base+6], 32'(retire_jump));
            check_value("retire_exception", golden[base+8], 32'(retire_exception));
            if (golden[base+3][0]) begin
                check_value("retire_waddr", golden[base+4], 32'(retire_waddr));
                check_value("retire_wdata", golden[base+5], retire_wdata);
            end
            // a misaligned jump still reports the target it tried to reach.
            if (golden[base+6][0] || (golden[base+8][0] &&
                golden[base+9] == 32'(except_misaligned_fetch))) begin
                check_value("retire_target", golden[base+7], retire_target);
            end
            if (golden[base+8][0]) begin
                check_value("retire_ecause", golden[base+9], 32'(retire_ecause));
            end
        end
    endtask

    initial begin
        logic gap;
        logic stall;
        logic offer_fire;
        reset = 1'b0;
        instr_valid = 1'b0;
        instr_pc = `RESET_PC;
        instr_data = `NOP_INSTR;
        retire_ready = 1'b0;
        lfsr_state = 32'd87776;
        next_line = 0;
        cycle_count = 0;
        for (int i = 0; i < MAX_LINES * FIELDS; i++) begin
            golden[i] = fill_word(i);
        end
        $readmemh("rv_golden.hex", golden);
        line_count = 0;
        while (line_count < MAX_LINES &&
               golden[line_count*FIELDS] != fill_word(line_count * FIELDS)) begin
            line_count++;
        end
        if (line_count == 0) begin
            abort_run("no trace lines were read from rv_golden.hex");
        end
        for (int i = 0; i < line_count; i++) begin
            if (golden[i*FIELDS+2][0]) begin
                expect_q.push_back(i);
            end
        end
        timeout_limit = 8 * line_count + 100;

        repeat (7) @(posedge clock);
        @(negedge clock);
        check_value("instr_ready", 32'd0, 32'(instr_ready));
        check_value("retire_valid", 32'd0, 32'(retire_valid));
        @(posedge clock);
        #1;
        reset = 1'b1;

        while (next_line < line_count || expect_q.size() > 0) begin
            if (!instr_valid && next_line < line_count) begin
                roll_quarter(gap);
                if (!gap) begin
                    offer_line(next_line);
                end
            end
            roll_quarter(stall);
            retire_ready = !stall;
            @(negedge clock);
            offer_fire = instr_valid && instr_ready;
            if (retire_valid && retire_ready) begin
                check_retire();
            end
            @(posedge clock);
            #1;
            cycle_count++;
            if (cycle_count > timeout_limit) begin
                abort_run($sformatf("timeout after %0d cycles with %0d records outstanding",
                                    cycle_count, expect_q.size()));
            end
            if (offer_fire) begin
                instr_valid = 1'b0;
                next_line++;
            end
        end

        // any record showing up now would be a duplicate or a wrong-path retire.
        retire_ready = 1'b1;
        repeat (8) begin
            @(negedge clock);
            if (retire_valid) begin
                check_retire();
            end
            @(posedge clock);
            #1;
        end
        $display(">>> PASS");
        $finish;
    end

endmodule
